// ==== hdl/core_pkg.sv ====
`default_nettype none

package core_pkg;

    import isa_pkg::*;

    typedef struct packed {
        alu_op_e alu_op;
        logic    alu_src_imm;    // operand b from immediate
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    mem_to_reg;
    } ctrl_t;

    typedef struct packed {
        ctrl_t                 ctrl;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       rs1_data;
        logic [XLEN-1:0]       rs2_data;
        logic [XLEN-1:0]       imm;
    } id_ex_t;

    typedef struct packed {
        ctrl_t                 ctrl;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       alu_result;
        logic [XLEN-1:0]       store_data;
    } ex_mem_t;

    typedef struct packed {
        logic                  reg_write;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       value;    // already muxed load or alu
    } mem_wb_t;

    typedef struct packed {
        logic                  valid;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       value;
    } fwd_t;

    typedef enum logic {
        DBG_MEM = 1'b0,
        DBG_REG = 1'b1
    } dbg_src_e;

endpackage

`default_nettype wire

// ==== hdl/cpu_top.sv ====
`default_nettype none
`timescale 1ns/10ps

module cpu_top
    import isa_pkg::*;
    import core_pkg::*;
#(
    parameter int IMEM_WORDS = 64,
    parameter int DMEM_WORDS = 32
)
(
    input  wire                   clk_i,
    input  wire                   reset,
    input  wire                   instr_valid_i,
    input  wire [7:0]             instr_byte_i,
    input  wire                   instr_last_i,
    output logic                  instr_ready_o,
    input  wire [REG_ADDR_W-1:0]  dbg_addr_i,
    input  wire dbg_src_e         dbg_src_i,
    input  wire [1:0]             dbg_byte_i,
    output logic [7:0]            dbg_value_o
);

    localparam int IAW = $clog2(IMEM_WORDS);

    logic            run;
    logic            imem_we;
    logic [IAW-1:0]  imem_addr;
    logic [XLEN-1:0] imem_data;
    logic            stall;
    logic            branch_taken;
    logic [XLEN-1:0] branch_target;
    logic [XLEN-1:0] if_pc;
    instr_u          if_instr;
    id_ex_t          id_ex;
    ex_mem_t         ex_mem;
    mem_wb_t         wb;
    fwd_t            fwd_mem;
    fwd_t            fwd_wb;
    logic [XLEN-1:0] dbg_reg;
    logic [XLEN-1:0] dbg_mem;
    logic [XLEN-1:0] dbg_word;

    program_loader #(.IMEM_WORDS(IMEM_WORDS)) loader_i (
        .clk_i, .reset, .instr_valid_i, .instr_byte_i, .instr_last_i, .instr_ready_o,
        .imem_we_o(imem_we), .imem_addr_o(imem_addr), .imem_data_o(imem_data), .run_o(run)
    );

    fetch_stage #(.IMEM_WORDS(IMEM_WORDS)) fetch_i (
        .clk_i, .reset, .run_i(run),
        .imem_we_i(imem_we), .imem_addr_i(imem_addr), .imem_data_i(imem_data),
        .stall_i(stall), .branch_taken_i(branch_taken), .branch_target_i(branch_target),
        .if_pc_o(if_pc), .if_instr_o(if_instr)
    );

    decode_stage decode_i (
        .clk_i, .reset, .run_i(run), .if_pc_i(if_pc), .if_instr_i(if_instr), .wb_i(wb),
        .dbg_addr_i, .dbg_reg_o(dbg_reg), .stall_o(stall),
        .branch_taken_o(branch_taken), .branch_target_o(branch_target), .id_ex_o(id_ex)
    );

    execute_stage execute_i (
        .clk_i, .reset, .run_i(run), .id_ex_i(id_ex),
        .fwd_mem_i(fwd_mem), .fwd_wb_i(fwd_wb), .ex_mem_o(ex_mem)
    );

    memory_stage #(.DMEM_WORDS(DMEM_WORDS)) memory_i (
        .clk_i, .reset, .run_i(run), .ex_mem_i(ex_mem), .dbg_addr_i,
        .dbg_mem_o(dbg_mem), .fwd_mem_o(fwd_mem), .wb_o(wb), .fwd_wb_o(fwd_wb)
    );

    // word by source, then one byte of it
    assign dbg_word    = (dbg_src_i == DBG_REG) ? dbg_reg : dbg_mem;
    assign dbg_value_o = dbg_word[8*dbg_byte_i +: 8];

endmodule

`default_nettype wire

// ==== hdl/decode_stage.sv ====
`default_nettype none
`timescale 1ns/10ps

module decode_stage
    import isa_pkg::*;
    import core_pkg::*;
(
    input  wire                    clk_i,
    input  wire                    reset,
    input  wire                    run_i,
    input  wire [XLEN-1:0]         if_pc_i,
    input  wire instr_u            if_instr_i,
    input  wire mem_wb_t           wb_i,
    input  wire [REG_ADDR_W-1:0]   dbg_addr_i,
    output logic [XLEN-1:0]        dbg_reg_o,
    output logic                   stall_o,
    output logic                   branch_taken_o,
    output logic [XLEN-1:0]        branch_target_o,
    output id_ex_t                 id_ex_o
);

    localparam int NREGS = 2 ** REG_ADDR_W;

    logic [XLEN-1:0] regs [NREGS];
    ctrl_t           ctrl;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic            is_beq;
    logic            uses_rs2;

    always_comb begin
        ctrl     = '0;
        imm      = '0;
        is_beq   = 1'b0;
        uses_rs2 = 1'b0;
        case (if_instr_i.r.opcode)
            OP: begin
                ctrl.reg_write = 1'b1;
                uses_rs2       = 1'b1;
                case (if_instr_i.r.funct3)
                    F3_AND:  ctrl.alu_op = ALU_AND;
                    F3_OR:   ctrl.alu_op = ALU_OR;
                    default: ctrl.alu_op = (if_instr_i.r.funct7 == F7_SUB) ? ALU_SUB : ALU_ADD;
                endcase
            end
            OP_IMM, LOAD: begin
                ctrl.alu_src_imm = 1'b1;
                ctrl.reg_write   = 1'b1;
                ctrl.mem_read    = (if_instr_i.i.opcode == LOAD);
                ctrl.mem_to_reg  = (if_instr_i.i.opcode == LOAD);
                imm = {{(XLEN-12){if_instr_i.i.imm[11]}}, if_instr_i.i.imm};
            end
            STORE: begin
                ctrl.alu_src_imm = 1'b1;
                ctrl.mem_write   = 1'b1;
                uses_rs2         = 1'b1;    // store data
                imm = {{(XLEN-12){if_instr_i.s.imm_hi[6]}}, if_instr_i.s.imm_hi,
                       if_instr_i.s.imm_lo};
            end
            BRANCH: begin
                uses_rs2 = 1'b1;
                is_beq   = (if_instr_i.b.funct3 == F3_ADD_SUB);
            end
            default: begin
            end
        endcase
    end

    // write-through so a result in writeback is seen this cycle
    assign rs1_data = (wb_i.reg_write && wb_i.rd != '0 && wb_i.rd == if_instr_i.r.rs1)
                    ? wb_i.value : regs[if_instr_i.r.rs1];
    assign rs2_data = (wb_i.reg_write && wb_i.rd != '0 && wb_i.rd == if_instr_i.r.rs2)
                    ? wb_i.value : regs[if_instr_i.r.rs2];
    assign dbg_reg_o = regs[dbg_addr_i];

    assign stall_o = id_ex_o.ctrl.mem_read && (id_ex_o.rd != '0)
                  && ((id_ex_o.rd == if_instr_i.r.rs1)
                   || (uses_rs2 && id_ex_o.rd == if_instr_i.r.rs2));

    assign imm_b = {{(XLEN-13){if_instr_i.b.imm12}}, if_instr_i.b.imm12, if_instr_i.b.imm11,
                    if_instr_i.b.imm10_5, if_instr_i.b.imm4_1, 1'b0};
    assign branch_taken_o  = is_beq && (rs1_data == rs2_data) && !stall_o;
    assign branch_target_o = if_pc_i + imm_b;

    always_ff @(posedge clk_i or posedge reset) begin
        if (reset) begin
            for (int k = 0; k < NREGS; k++) begin
                regs[k] <= '0;
            end
        end else if (wb_i.reg_write && wb_i.rd != '0) begin    // x0 stays zero
            regs[wb_i.rd] <= wb_i.value;
        end
    end

    always_ff @(posedge clk_i or posedge reset) begin
        if (reset) begin
            id_ex_o <= '0;
        end else if (run_i) begin
            if (stall_o) begin
                id_ex_o <= '0;    // bubble behind the load
            end else begin
                id_ex_o.ctrl     <= ctrl;
                id_ex_o.rs1      <= if_instr_i.r.rs1;
                id_ex_o.rs2      <= if_instr_i.r.rs2;
                id_ex_o.rd       <= if_instr_i.r.rd;
                id_ex_o.rs1_data <= rs1_data;
                id_ex_o.rs2_data <= rs2_data;
                id_ex_o.imm      <= imm;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/execute_stage.sv ====
`default_nettype none
`timescale 1ns/10ps

module execute_stage
    import isa_pkg::*;
    import core_pkg::*;
(
    input  wire          clk_i,
    input  wire          reset,
    input  wire          run_i,
    input  wire id_ex_t  id_ex_i,
    input  wire fwd_t    fwd_mem_i,
    input  wire fwd_t    fwd_wb_i,
    output ex_mem_t      ex_mem_o
);

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] rs2_val;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] result;

    function automatic logic [XLEN-1:0] forward(
        input logic [REG_ADDR_W-1:0] idx,
        input logic [XLEN-1:0]       reg_val,
        input fwd_t                  mem_src,
        input fwd_t                  wb_src
    );
        if (idx != '0 && mem_src.valid && mem_src.rd == idx) begin
            return mem_src.value;    // newest result wins
        end
        if (idx != '0 && wb_src.valid && wb_src.rd == idx) begin
            return wb_src.value;
        end
        return reg_val;
    endfunction

    assign op_a    = forward(id_ex_i.rs1, id_ex_i.rs1_data, fwd_mem_i, fwd_wb_i);
    assign rs2_val = forward(id_ex_i.rs2, id_ex_i.rs2_data, fwd_mem_i, fwd_wb_i);
    assign op_b    = id_ex_i.ctrl.alu_src_imm ? id_ex_i.imm : rs2_val;

    always_comb begin
        case (id_ex_i.ctrl.alu_op)
            ALU_SUB: result = op_a - op_b;
            ALU_AND: result = op_a & op_b;
            ALU_OR:  result = op_a | op_b;
            default: result = op_a + op_b;    // add, addi, address calc
        endcase
    end

    always_ff @(posedge clk_i or posedge reset) begin
        if (reset) begin
            ex_mem_o <= '0;
        end else if (run_i) begin
            ex_mem_o.ctrl       <= id_ex_i.ctrl;
            ex_mem_o.rd         <= id_ex_i.rd;
            ex_mem_o.alu_result <= result;
            ex_mem_o.store_data <= rs2_val;    // forwarded sw data
        end
    end

endmodule

`default_nettype wire

// ==== hdl/fetch_stage.sv ====
`default_nettype none
`timescale 1ns/10ps

module fetch_stage
    import isa_pkg::*;
#(
    parameter int IMEM_WORDS = 64
)
(
    input  wire                          clk_i,
    input  wire                          reset,
    input  wire                          run_i,
    input  wire                          imem_we_i,
    input  wire [$clog2(IMEM_WORDS)-1:0] imem_addr_i,
    input  wire [XLEN-1:0]               imem_data_i,
    input  wire                          stall_i,
    input  wire                          branch_taken_i,
    input  wire [XLEN-1:0]               branch_target_i,
    output logic [XLEN-1:0]              if_pc_o,
    output instr_u                       if_instr_o
);

    localparam int AW = $clog2(IMEM_WORDS);

    logic [XLEN-1:0] imem [IMEM_WORDS];
    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] fetched;

    assign fetched = imem[pc_q[AW+1:2]];    // word index from byte pc

    always_ff @(posedge clk_i) begin
        if (imem_we_i) begin
            imem[imem_addr_i] <= imem_data_i;
        end
    end

    always_ff @(posedge clk_i or posedge reset) begin
        if (reset) begin
            pc_q <= '0;
        end else if (run_i) begin
            if (branch_taken_i) begin
                pc_q <= branch_target_i;
            end else if (!stall_i) begin
                pc_q <= pc_q + XLEN'(4);
            end
        end
    end

    always_ff @(posedge clk_i or posedge reset) begin
        if (reset) begin
            if_pc_o    <= '0;
            if_instr_o <= NOP_INSTR;
        end else if (run_i) begin
            if (branch_taken_i) begin
                if_instr_o <= NOP_INSTR;    // drop the wrong-path word
            end else if (!stall_i) begin
                if_pc_o    <= pc_q;
                if_instr_o <= fetched;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

    localparam int XLEN       = 32;    // data and instruction word
    localparam int REG_ADDR_W = 5;

    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011
    } opcode_e;

    typedef enum logic [1:0] {
        ALU_ADD = 2'd0,
        ALU_SUB = 2'd1,
        ALU_AND = 2'd2,
        ALU_OR  = 2'd3
    } alu_op_e;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;    // also beq
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [6:0] F7_SUB     = 7'b0100000;

    localparam logic [XLEN-1:0] NOP_INSTR = 32'h0000_0013;    // addi x0, x0, 0

    typedef struct packed {
        logic [6:0]            funct7;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        opcode_e               opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0]           imm;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        opcode_e               opcode;
    } i_type_t;

    typedef struct packed {
        logic [6:0]            imm_hi;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [4:0]            imm_lo;
        opcode_e               opcode;
    } s_type_t;

    typedef struct packed {
        logic                  imm12;
        logic [5:0]            imm10_5;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [3:0]            imm4_1;
        logic                  imm11;
        opcode_e               opcode;
    } b_type_t;

    // one instruction word, four ways to read it
    typedef union packed {
        r_type_t r;
        i_type_t i;
        s_type_t s;
        b_type_t b;
    } instr_u;

endpackage

`default_nettype wire

// ==== hdl/memory_stage.sv ====
`default_nettype none
`timescale 1ns/10ps

module memory_stage
    import isa_pkg::*;
    import core_pkg::*;
#(
    parameter int DMEM_WORDS = 32
)
(
    input  wire                   clk_i,
    input  wire                   reset,
    input  wire                   run_i,
    input  wire ex_mem_t          ex_mem_i,
    input  wire [REG_ADDR_W-1:0]  dbg_addr_i,
    output logic [XLEN-1:0]       dbg_mem_o,
    output fwd_t                  fwd_mem_o,
    output mem_wb_t               wb_o,
    output fwd_t                  fwd_wb_o
);

    localparam int DAW = $clog2(DMEM_WORDS);

    logic [XLEN-1:0] dmem [DMEM_WORDS];
    logic [DAW-1:0]  word_idx;
    logic [XLEN-1:0] load_data;

    assign word_idx  = ex_mem_i.alu_result[DAW+1:2];    // byte address to word
    assign load_data = dmem[word_idx];
    assign dbg_mem_o = dmem[DAW'(dbg_addr_i)];

    // a load result is not ready in this stage, the stall covers it
    assign fwd_mem_o = '{valid: ex_mem_i.ctrl.reg_write && !ex_mem_i.ctrl.mem_to_reg,
                         rd:    ex_mem_i.rd,
                         value: ex_mem_i.alu_result};
    assign fwd_wb_o  = '{valid: wb_o.reg_write, rd: wb_o.rd, value: wb_o.value};

    always_ff @(posedge clk_i or posedge reset) begin
        if (reset) begin
            for (int k = 0; k < DMEM_WORDS; k++) begin
                dmem[k] <= '0;
            end
        end else if (run_i && ex_mem_i.ctrl.mem_write) begin
            dmem[word_idx] <= ex_mem_i.store_data;
        end
    end

    always_ff @(posedge clk_i or posedge reset) begin
        if (reset) begin
            wb_o <= '0;
        end else if (run_i) begin
            wb_o.reg_write <= ex_mem_i.ctrl.reg_write;
            wb_o.rd        <= ex_mem_i.rd;
            wb_o.value     <= ex_mem_i.ctrl.mem_to_reg ? load_data : ex_mem_i.alu_result;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/program_loader.sv ====
`default_nettype none
`timescale 1ns/10ps

module program_loader
    import isa_pkg::*;
#(
    parameter int IMEM_WORDS = 64
)
(
    input  wire                          clk_i,
    input  wire                          reset,
    input  wire                          instr_valid_i,
    input  wire [7:0]                    instr_byte_i,
    input  wire                          instr_last_i,
    output logic                         instr_ready_o,
    output logic                         imem_we_o,
    output logic [$clog2(IMEM_WORDS)-1:0] imem_addr_o,
    output logic [XLEN-1:0]              imem_data_o,
    output logic                         run_o
);

    localparam int AW = $clog2(IMEM_WORDS);

    logic              loaded_q;       // set once the last beat is taken
    logic [1:0]        lane_q;
    logic [XLEN-9:0]   low_bytes_q;    // first three bytes of a word
    logic              beat;

    assign instr_ready_o = !loaded_q;
    assign run_o         = loaded_q;
    assign beat          = instr_valid_i && instr_ready_o;
    assign imem_we_o     = beat && (lane_q == 2'd3);
    assign imem_data_o   = {instr_byte_i, low_bytes_q};    // lsb first

    always_ff @(posedge clk_i or posedge reset) begin
        if (reset) begin
            loaded_q    <= 1'b0;
            lane_q      <= '0;
            imem_addr_o <= '0;
        end else if (beat) begin
            lane_q <= lane_q + 2'd1;
            if (lane_q == 2'd3) begin
                imem_addr_o <= imem_addr_o + AW'(1);
            end
            if (instr_last_i) begin
                loaded_q <= 1'b1;    // ready drops, core starts
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (beat) begin
            low_bytes_q <= {instr_byte_i, low_bytes_q[XLEN-9:8]};
        end
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# build the testbench with Verilator, run it, pass only on the pass message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -j 0 -f sources.f --top-module cpu_tb -o cpu_sim \
    || { echo "build failed"; exit 1; }
out="$(./obj_dir/cpu_sim)"
printf '%s\n' "$out"
grep -qx "Everything OK" <<< "$out" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== sources.f ====
hdl/isa_pkg.sv
hdl/core_pkg.sv
hdl/program_loader.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/memory_stage.sv
hdl/cpu_top.sv
tb/cpu_tb.sv

// ==== tb/cpu_tb.sv ====
`default_nettype none
`timescale 1ns/10ps

module cpu_tb
    import isa_pkg::*;
    import core_pkg::*;
();

    localparam int MAX_TESTS = 16;

    logic                  clk;
    logic                  reset;
    logic                  instr_valid;
    logic [7:0]            instr_byte;
    logic                  instr_last;
    logic                  instr_ready;
    logic [REG_ADDR_W-1:0] dbg_addr;
    dbg_src_e              dbg_src;
    logic [1:0]            dbg_byte;
    logic [7:0]            dbg_value;

    string           test_name [MAX_TESTS];
    int              word_first [MAX_TESTS];
    int              word_count [MAX_TESTS];
    int              exp_first [MAX_TESTS];
    int              exp_count [MAX_TESTS];
    logic [XLEN-1:0] prog_words [$];
    logic            exp_is_reg [$];    // register or data memory
    int              exp_index [$];
    logic [XLEN-1:0] exp_value [$];

    int num_tests;
    int seed;
    int cycles;
    int cycle_limit;
    int checks;
    int errors;
    int failed_tests;
    bit read_ok;

    cpu_top #(.IMEM_WORDS(64), .DMEM_WORDS(32)) dut_i (
        .clk_i(clk), .reset(reset),
        .instr_valid_i(instr_valid), .instr_byte_i(instr_byte), .instr_last_i(instr_last),
        .instr_ready_o(instr_ready),
        .dbg_addr_i(dbg_addr), .dbg_src_i(dbg_src), .dbg_byte_i(dbg_byte),
        .dbg_value_o(dbg_value)
    );

    always #10 clk = ~clk;    // 20 ns period

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Something failed");
            $finish;
        end
    end

    task automatic read_tests(output bit ok);
        int              fd;
        int              code;
        int              n;
        int              idx;
        logic [XLEN-1:0] word;
        reg [8*32-1:0]   tag;
        reg [8*32-1:0]   name;
        reg [8*128-1:0]  rest;
        ok = 1'b1;
        num_tests = 0;
        fd = $fopen("tb/cpu_tests.txt", "r");
        if (fd == 0) begin
            ok = 1'b0;
        end else begin
            while (!$feof(fd) && ok) begin
                code = $fscanf(fd, "%s", tag);
                if (code == 1) begin
                    if (string'(tag) == "#") begin
                        code = $fgets(rest, fd);    // skip comment text
                    end else if (string'(tag) == "test") begin
                        code = $fscanf(fd, "%s", name);
                        ok = (num_tests < MAX_TESTS);
                        if (ok) begin
                            test_name[num_tests]  = string'(name);
                            word_first[num_tests] = prog_words.size();
                            word_count[num_tests] = 0;
                            exp_first[num_tests]  = exp_value.size();
                            exp_count[num_tests]  = 0;
                        end
                    end else if (string'(tag) == "p") begin
                        code = $fscanf(fd, "%d", n);
                        for (int k = 0; k < n; k++) begin
                            code = $fscanf(fd, "%h", word);
                            prog_words.push_back(word);
                        end
                        word_count[num_tests] += n;
                    end else if (string'(tag) == "r" || string'(tag) == "m") begin
                        code = $fscanf(fd, "%d %h", idx, word);
                        exp_is_reg.push_back(string'(tag) == "r");
                        exp_index.push_back(idx);
                        exp_value.push_back(word);
                        exp_count[num_tests]++;
                    end else if (string'(tag) == "end") begin
                        num_tests++;
                    end else begin
                        ok = 1'b0;    // unknown line tag
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // lsb first, idle gaps only ahead of a word's first byte
    task automatic load_program(input int t);
        int              gap;
        logic [XLEN-1:0] word;
        for (int w = 0; w < word_count[t]; w++) begin
            word = prog_words[word_first[t] + w];
            for (int b = 0; b < 4; b++) begin
                gap = (b == 0) ? ($random(seed) & 1) : 0;
                repeat (gap) begin
                    @(negedge clk);
                    instr_valid = 1'b0;
                end
                @(negedge clk);
                instr_valid = 1'b1;
                instr_byte  = word[8*b +: 8];
                instr_last  = (w == word_count[t] - 1) && (b == 3);
                while (!instr_ready) @(negedge clk);    // hold until taken
            end
        end
        @(negedge clk);
        instr_valid = 1'b0;
        instr_last  = 1'b0;
    endtask

    task automatic read_word(input logic is_reg, input int idx, output logic [XLEN-1:0] value);
        value = '0;
        for (int b = 0; b < 4; b++) begin
            @(negedge clk);
            dbg_addr = idx[REG_ADDR_W-1:0];
            dbg_src  = is_reg ? DBG_REG : DBG_MEM;
            dbg_byte = b[1:0];
            @(posedge clk);
            value[8*b +: 8] = dbg_value;
        end
    endtask

    task automatic run_test(input int t);
        int              fails;
        logic [XLEN-1:0] got;
        fails = 0;
        @(negedge clk);
        reset = 1'b1;
        repeat (8) @(negedge clk);
        reset = 1'b0;
        checks++;
        if (instr_ready !== 1'b1) begin
            $display("Test %s: instr_ready_o is not high after reset", test_name[t]);
            fails++;
        end
        load_program(t);
        checks++;
        if (instr_ready !== 1'b0) begin
            $display("Test %s: instr_ready_o is still high after the last byte", test_name[t]);
            fails++;
        end
        repeat (64) @(negedge clk);    // program runs into its self-loop
        for (int e = exp_first[t]; e < exp_first[t] + exp_count[t]; e++) begin
            read_word(exp_is_reg[e], exp_index[e], got);
            checks++;
            if (got !== exp_value[e]) begin
                $display("Mismatch in %s: %s[%0d] expected %08h actual %08h", test_name[t],
                         exp_is_reg[e] ? "reg" : "mem", exp_index[e], exp_value[e], got);
                fails++;
            end
        end
        errors += fails;
        if (fails == 0) begin
            $display("Test %s: passed, %0d values read back", test_name[t], exp_count[t]);
        end else begin
            $display("Test %s: failed with %0d errors", test_name[t], fails);
            failed_tests++;
        end
    endtask

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        instr_valid  = 1'b0;
        instr_byte   = '0;
        instr_last   = 1'b0;
        dbg_addr     = '0;
        dbg_src      = DBG_REG;
        dbg_byte     = '0;
        seed         = 32'hb015d65d;
        cycles       = 0;
        cycle_limit  = 0;
        checks       = 0;
        errors       = 0;
        failed_tests = 0;
        read_tests(read_ok);
        if (!read_ok || num_tests == 0) begin
            $display("Could not read the tests from tb/cpu_tests.txt");
            $display("Something failed");
            $finish;
        end else begin
            for (int t = 0; t < num_tests; t++) begin
                cycle_limit += 8 + 4 * word_count[t] * 2 + 64 + 16;
            end
            for (int t = 0; t < num_tests; t++) begin
                run_test(t);
            end
            $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
                     num_tests, failed_tests, checks, errors);
            if (errors == 0) begin
                $display("Everything OK");
            end else begin
                $display("Something failed");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== tb/cpu_tests.txt ====
# test <name> opens a test, p <count> <hex words> gives program words, end closes it
# r <index> <hex> expects register x<index>, m <index> <hex> expects data memory word <index>
test alu_chain
p 4 05500093 00f08113 002081b3 40310233
p 4 003272b3 0022e333 fff30393 00000063
r 2 00000064
r 3 000000b9
r 4 ffffffab
r 5 000000a9
r 6 000000ed
r 7 000000ec
r 0 00000000
end
test load_store
p 4 12300093 00800113 00112223 00412183
p 4 00118233 00402023 00002283 40328333
p 1 00000063
m 3 00000123
m 0 00000246
r 3 00000123
r 4 00000246
r 5 00000246
r 6 00000123
m 31 00000000
end
test branches
p 4 00300093 00300113 00400193 00100513
p 4 00200593 00308463 07700613 00208463
p 3 06600693 05500713 00000063
r 11 00000002
r 12 00000077
r 13 00000000
r 14 00000055
r 0 00000000
m 0 00000000
end
test byte_readout
p 4 5a100093 00108133 002101b3 00318233
p 4 004202b3 00528333 006303b3 00738433
p 3 408004b3 00902423 00000063
r 1 000005a1
r 8 0002d080
r 9 fffd2f80
m 2 fffd2f80
m 1 00000000
r 0 00000000
end
